// ==== hw/int_core_params.svh ====
`ifndef INT_CORE_PARAMS_SVH
`define INT_CORE_PARAMS_SVH

// datapath width
`define CORE_XLEN       32

// register file geometry
`define CORE_RADDR_W    5
`define CORE_NR_REGS    32

`define CORE_INST_W     32   // one MIPS word per strobe
`define CORE_SHAMT_W    5    // shifts use low 5 bits

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field under SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS_MSB     = 25;
    localparam int RS_LSB     = 21;
    localparam int RT_MSB     = 20;
    localparam int RT_LSB     = 16;
    localparam int RD_MSB     = 15;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_MSB  = 10;
    localparam int SHAMT_LSB  = 6;
    localparam int IMM_MSB    = 15;   // also the sign bit
    localparam int IMM_LSB    = 0;
    localparam int FUNCT_MSB  = 5;
    localparam int FUNCT_LSB  = 0;

endpackage

// ==== hw/core_pkg.sv ====
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_NOR  = 4'h5,
        ALU_SLT  = 4'h6,
        ALU_SLTU = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRL  = 4'h9,
        ALU_SRA  = 4'ha,
        ALU_LUI  = 4'hb
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        OPA_RS  = 2'd0,
        OPA_RT  = 2'd1,
        OPA_FWD = 2'd2,   // result register of execute
        OPA_IMM = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RT    = 3'd0,
        OPB_RS    = 3'd1,   // variable shifts
        OPB_IMM   = 3'd2,
        OPB_SHAMT = 3'd3,
        OPB_FWD   = 3'd4
    } opb_sel_e;

endpackage

// ==== hw/inst_decoder.sv ====
`include "int_core_params.svh"

module inst_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid_i,
    input  logic [`CORE_INST_W-1:0]   inst_data_i,
    output logic                      dec_valid_o,
    output core_pkg::alu_op_e         alu_op_o,
    output core_pkg::opa_sel_e        opa_sel_o,
    output core_pkg::opb_sel_e        opb_sel_o,
    output logic [`CORE_XLEN-1:0]     imm_o,
    output logic [`CORE_SHAMT_W-1:0]  shamt_o,
    output logic [`CORE_RADDR_W-1:0]  wb_addr_o,
    output logic                      wb_en_o,
    output logic                      illegal_o
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_e                   opcode;
    funct_e                    funct;
    logic [`CORE_RADDR_W-1:0]  rs;
    logic [`CORE_RADDR_W-1:0]  rt;
    logic [`CORE_RADDR_W-1:0]  rd;
    logic [`CORE_RADDR_W-1:0]  dst;
    logic                      fwd_ok;
    logic                      rs_hit;
    logic                      rt_hit;
    logic                      legal;
    logic                      imm_sext;
    logic                      dst_rd;
    alu_op_e                   alu_op_d;
    opa_sel_e                  opa_d;
    opb_sel_e                  opb_d;

    assign opcode = opcode_e'(inst_data_i[OPCODE_MSB:OPCODE_LSB]);
    assign funct  = funct_e'(inst_data_i[FUNCT_MSB:FUNCT_LSB]);
    assign rs     = inst_data_i[RS_MSB:RS_LSB];
    assign rt     = inst_data_i[RT_MSB:RT_LSB];
    assign rd     = inst_data_i[RD_MSB:RD_LSB];

    // destination of the item now in execute, none on a bubble
    assign fwd_ok = dec_valid_o && wb_en_o;
    assign rs_hit = fwd_ok && (rs == wb_addr_o);
    assign rt_hit = fwd_ok && (rt == wb_addr_o);

    always_comb begin
        legal    = 1'b1;
        imm_sext = 1'b0;
        dst_rd   = 1'b0;
        alu_op_d = ALU_ADD;
        opa_d    = rs_hit ? OPA_FWD : OPA_RS;
        opb_d    = OPB_IMM;
        case (opcode)
            OP_SPECIAL: begin
                dst_rd = 1'b1;
                opb_d  = rt_hit ? OPB_FWD : OPB_RT;
                case (funct)
                    FN_ADDU: alu_op_d = ALU_ADD;
                    FN_SUBU: alu_op_d = ALU_SUB;
                    FN_AND:  alu_op_d = ALU_AND;
                    FN_OR:   alu_op_d = ALU_OR;
                    FN_XOR:  alu_op_d = ALU_XOR;
                    FN_NOR:  alu_op_d = ALU_NOR;
                    FN_SLT:  alu_op_d = ALU_SLT;
                    FN_SLTU: alu_op_d = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        opa_d = rt_hit ? OPA_FWD : OPA_RT;   // shifted value is rt
                        opb_d = OPB_SHAMT;
                        alu_op_d = (funct == FN_SLL) ? ALU_SLL :
                                   (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        opa_d = rt_hit ? OPA_FWD : OPA_RT;
                        opb_d = rs_hit ? OPB_FWD : OPB_RS;   // amount from rs
                        alu_op_d = (funct == FN_SLLV) ? ALU_SLL :
                                   (funct == FN_SRLV) ? ALU_SRL : ALU_SRA;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op_d = ALU_ADD;
                imm_sext = 1'b1;
            end
            OP_SLTI: begin
                alu_op_d = ALU_SLT;
                imm_sext = 1'b1;
            end
            OP_SLTIU: begin
                alu_op_d = ALU_SLTU;
                imm_sext = 1'b1;   // sign-extended, compared unsigned
            end
            OP_ANDI: alu_op_d = ALU_AND;
            OP_ORI:  alu_op_d = ALU_OR;
            OP_XORI: alu_op_d = ALU_XOR;
            OP_LUI: begin
                alu_op_d = ALU_LUI;
                opa_d    = OPA_IMM;
            end
            default: legal = 1'b0;
        endcase
    end

    assign dst = dst_rd ? rd : rt;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o <= 1'b0;
            alu_op_o    <= ALU_ADD;
            opa_sel_o   <= OPA_RS;
            opb_sel_o   <= OPB_RT;
            imm_o       <= '0;
            shamt_o     <= '0;
            wb_addr_o   <= '0;
            wb_en_o     <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                alu_op_o  <= alu_op_d;
                opa_sel_o <= opa_d;
                opb_sel_o <= opb_d;
                imm_o     <= {{(`CORE_XLEN-16){imm_sext & inst_data_i[IMM_MSB]}},
                              inst_data_i[IMM_MSB:IMM_LSB]};
                shamt_o   <= inst_data_i[SHAMT_MSB:SHAMT_LSB];
                wb_addr_o <= dst;
                wb_en_o   <= legal && (dst != '0);   // r0 writes dropped here
                illegal_o <= ~legal;
            end
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`include "int_core_params.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en_i,
    input  logic [`CORE_RADDR_W-1:0]  rs_addr_i,
    input  logic [`CORE_RADDR_W-1:0]  rt_addr_i,
    output logic [`CORE_XLEN-1:0]     rs_data_o,
    output logic [`CORE_XLEN-1:0]     rt_data_o,
    input  logic                      we_i,
    input  logic [`CORE_RADDR_W-1:0]  waddr_i,
    input  logic [`CORE_XLEN-1:0]     wdata_i
);

    logic [`CORE_XLEN-1:0]  regs [`CORE_NR_REGS];
    logic                   wr_ok;

    assign wr_ok = we_i && (waddr_i != '0);   // r0 never written

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) begin
                regs[i] <= '0;
            end
            rs_data_o <= '0;
            rt_data_o <= '0;
        end else begin
            if (wr_ok) begin
                regs[waddr_i] <= wdata_i;
            end
            if (rd_en_i) begin
                // same-edge write shows through
                rs_data_o <= (wr_ok && waddr_i == rs_addr_i) ? wdata_i : regs[rs_addr_i];
                rt_data_o <= (wr_ok && waddr_i == rt_addr_i) ? wdata_i : regs[rt_addr_i];
            end
        end
    end

endmodule

// ==== hw/alu_exec.sv ====
`include "int_core_params.svh"

module alu_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid_i,
    input  core_pkg::alu_op_e         alu_op_i,
    input  core_pkg::opa_sel_e        opa_sel_i,
    input  core_pkg::opb_sel_e        opb_sel_i,
    input  logic [`CORE_XLEN-1:0]     imm_i,
    input  logic [`CORE_SHAMT_W-1:0]  shamt_i,
    input  logic [`CORE_RADDR_W-1:0]  wb_addr_i,
    input  logic                      wb_en_i,
    input  logic                      illegal_i,
    input  logic [`CORE_XLEN-1:0]     rs_data_i,
    input  logic [`CORE_XLEN-1:0]     rt_data_i,
    output logic                      wb_valid_o,
    output logic [`CORE_RADDR_W-1:0]  wb_addr_o,
    output logic [`CORE_XLEN-1:0]     wb_data_o,
    output logic                      illegal_o
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0]     opa;
    logic [`CORE_XLEN-1:0]     opb;
    logic [`CORE_XLEN-1:0]     res;
    logic [`CORE_SHAMT_W-1:0]  sh;

    always_comb begin
        case (opa_sel_i)
            OPA_RS:  opa = rs_data_i;
            OPA_RT:  opa = rt_data_i;
            OPA_FWD: opa = wb_data_o;   // previous result
            OPA_IMM: opa = imm_i;
            default: opa = rs_data_i;
        endcase
    end

    always_comb begin
        case (opb_sel_i)
            OPB_RT:    opb = rt_data_i;
            OPB_RS:    opb = rs_data_i;
            OPB_IMM:   opb = imm_i;
            OPB_SHAMT: opb = {{(`CORE_XLEN-`CORE_SHAMT_W){1'b0}}, shamt_i};
            OPB_FWD:   opb = wb_data_o;
            default:   opb = rt_data_i;
        endcase
    end

    assign sh = opb[`CORE_SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  res = opa + opb;
            ALU_SUB:  res = opa - opb;
            ALU_AND:  res = opa & opb;
            ALU_OR:   res = opa | opb;
            ALU_XOR:  res = opa ^ opb;
            ALU_NOR:  res = ~(opa | opb);
            ALU_SLT:  res = {{(`CORE_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: res = {{(`CORE_XLEN-1){1'b0}}, opa < opb};
            ALU_SLL:  res = opa << sh;
            ALU_SRL:  res = opa >> sh;
            ALU_SRA:  res = $unsigned($signed(opa) >>> sh);
            ALU_LUI:  res = {opa[`CORE_XLEN/2-1:0], {(`CORE_XLEN/2){1'b0}}};
            default:  res = '0;
        endcase
    end

    // result register doubles as the forwarding source
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_addr_o  <= '0;
            wb_data_o  <= '0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= dec_valid_i && wb_en_i;
            illegal_o  <= dec_valid_i && illegal_i;
            if (dec_valid_i) begin
                wb_addr_o <= wb_addr_i;
                wb_data_o <= res;
            end
        end
    end

endmodule

// ==== hw/int_core.sv ====
`include "int_core_params.svh"

module int_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid_i,
    input  logic [`CORE_INST_W-1:0]   inst_data_i,
    output logic                      wb_valid_o,
    output logic [`CORE_RADDR_W-1:0]  wb_addr_o,
    output logic [`CORE_XLEN-1:0]     wb_data_o,
    output logic                      illegal_o
);
    import isa_pkg::*;
    import core_pkg::*;

    logic                      dec_valid;
    alu_op_e                   alu_op;
    opa_sel_e                  opa_sel;
    opb_sel_e                  opb_sel;
    logic [`CORE_XLEN-1:0]     imm;
    logic [`CORE_SHAMT_W-1:0]  shamt;
    logic [`CORE_RADDR_W-1:0]  dec_wb_addr;
    logic                      dec_wb_en;
    logic                      dec_illegal;
    logic [`CORE_XLEN-1:0]     rs_data;
    logic [`CORE_XLEN-1:0]     rt_data;

    inst_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_data_i  (inst_data_i),
        .dec_valid_o  (dec_valid),
        .alu_op_o     (alu_op),
        .opa_sel_o    (opa_sel),
        .opb_sel_o    (opb_sel),
        .imm_o        (imm),
        .shamt_o      (shamt),
        .wb_addr_o    (dec_wb_addr),
        .wb_en_o      (dec_wb_en),
        .illegal_o    (dec_illegal)
    );

    // read runs beside decode
    reg_file u_rf (
        .clk       (clk),
        .rst       (rst),
        .rd_en_i   (inst_valid_i),
        .rs_addr_i (inst_data_i[RS_MSB:RS_LSB]),
        .rt_addr_i (inst_data_i[RT_MSB:RT_LSB]),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .we_i      (wb_valid_o),
        .waddr_i   (wb_addr_o),
        .wdata_i   (wb_data_o)
    );

    alu_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .dec_valid_i (dec_valid),
        .alu_op_i    (alu_op),
        .opa_sel_i   (opa_sel),
        .opb_sel_i   (opb_sel),
        .imm_i       (imm),
        .shamt_i     (shamt),
        .wb_addr_i   (dec_wb_addr),
        .wb_en_i     (dec_wb_en),
        .illegal_i   (dec_illegal),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .wb_valid_o  (wb_valid_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .illegal_o   (illegal_o)
    );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2;   // period of 4

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

// ==== testbench/tb_int_core.sv ====
`include "int_core_params.svh"

module tb_int_core;
    import isa_pkg::*;

    localparam int RESET_LEN  = 10;
    localparam int NR_ROUNDS  = 8;
    localparam int CHAIN_LEN  = 12;
    localparam int NR_ILLEGAL = 10;
    localparam int DRAIN_LEN  = 3;
    localparam int IMM_LEN    = 2 * 31 + 7 * NR_ROUNDS;   // register loads, then ops
    localparam int REG_LEN    = 8 * NR_ROUNDS;
    localparam int SHIFT_LEN  = 7 * NR_ROUNDS;
    localparam int FWD_LEN    = 6 * CHAIN_LEN;            // gaps of 0, 1 and 2
    localparam int ZERO_LEN   = 4 + 3 * NR_ILLEGAL;
    localparam int MAX_CYCLES = RESET_LEN + IMM_LEN + REG_LEN + SHIFT_LEN + FWD_LEN
                              + ZERO_LEN + 5 * DRAIN_LEN + 100;

    localparam opcode_e IMM_OPS [7] = '{OP_ORI, OP_ADDIU, OP_ANDI, OP_XORI,
                                        OP_SLTI, OP_SLTIU, OP_LUI};
    localparam funct_e REG_FNS [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                       FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam funct_e SHIFT_FNS [6] = '{FN_SRA, FN_SRL, FN_SLL, FN_SRAV, FN_SRLV, FN_SLLV};

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    logic [`CORE_INST_W-1:0]   inst_data;
    logic                      wb_valid;
    logic [`CORE_RADDR_W-1:0]  wb_addr;
    logic [`CORE_XLEN-1:0]     wb_data;
    logic                      illegal;

    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int seed   = 32'h63ed;

    logic [`CORE_XLEN-1:0]     model_regs [`CORE_NR_REGS];
    int                        exp_due [$];   // cycle at which the pulse is due
    logic [`CORE_RADDR_W-1:0]  exp_addr [$];
    logic [`CORE_XLEN-1:0]     exp_data [$];
    int                        ill_due [$];

    tb_clock clk_gen (
        .clk_o (clk)
    );

    int_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid),
        .inst_data_i  (inst_data),
        .wb_valid_o   (wb_valid),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data),
        .illegal_o    (illegal)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand32();
        return r[4:0];
    endfunction

    function automatic logic [31:0] r_type(input funct_e fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // architectural result of one word against the model registers
    task automatic predict(input logic [31:0] w, output logic legal,
                           output logic [4:0] dst, output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [4:0]  sa;
        a     = model_regs[w[25:21]];
        b     = model_regs[w[20:16]];
        sa    = w[10:6];
        simm  = {{16{w[15]}}, w[15:0]};
        zimm  = {16'h0000, w[15:0]};
        legal = 1'b1;
        dst   = w[20:16];
        val   = '0;
        case (w[31:26])
            OP_SPECIAL: begin
                dst = w[15:11];
                case (w[5:0])
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_NOR:  val = ~(a | b);
                    FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  val = b << sa;
                    FN_SRL:  val = b >> sa;
                    FN_SRA:  val = $signed(b) >>> sa;
                    FN_SLLV: val = b << a[4:0];
                    FN_SRLV: val = b >> a[4:0];
                    FN_SRAV: val = $signed(b) >>> a[4:0];
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: val = a + simm;
            OP_SLTI:  val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: val = (a < simm) ? 32'd1 : 32'd0;   // unsigned compare
            OP_ANDI:  val = a & zimm;
            OP_ORI:   val = a | zimm;
            OP_XORI:  val = a ^ zimm;
            OP_LUI:   val = {w[15:0], 16'h0000};
            default:  legal = 1'b0;
        endcase
    endtask

    task automatic check_outputs();
        while (exp_due.size() > 0 && exp_due[0] < cycles) begin
            $display("write-back to r%0d never came, was due at cycle %0d",
                     exp_addr[0], exp_due[0]);
            errors++;
            void'(exp_due.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
        while (ill_due.size() > 0 && ill_due[0] < cycles) begin
            $display("illegal_o never rose, was due at cycle %0d", ill_due[0]);
            errors++;
            void'(ill_due.pop_front());
        end
        if (wb_valid !== 1'b0) begin
            if (exp_due.size() == 0 || exp_due[0] != cycles) begin
                $display("unexpected write-back pulse at %0t to r%0d", $time, wb_addr);
                errors++;
            end else begin
                checks++;
                if (wb_addr !== exp_addr[0]) begin
                    $display("mismatch at %0t: wb_addr_o got %0d expected %0d",
                             $time, wb_addr, exp_addr[0]);
                    errors++;
                end
                if (wb_data !== exp_data[0]) begin
                    $display("mismatch at %0t: wb_data_o got %h expected %h",
                             $time, wb_data, exp_data[0]);
                    errors++;
                end
                void'(exp_due.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (illegal !== 1'b0) begin
            if (ill_due.size() == 0 || ill_due[0] != cycles) begin
                $display("unexpected illegal_o pulse at %0t", $time);
                errors++;
            end else begin
                checks++;
                void'(ill_due.pop_front());
            end
        end
    endtask

    // result shows two posedges after the capture edge
    task automatic issue(input logic [31:0] w);
        logic        legal;
        logic [4:0]  dst;
        logic [31:0] val;
        @(negedge clk);
        check_outputs();
        inst_valid = 1'b1;
        inst_data  = w;
        predict(w, legal, dst, val);
        if (!legal) begin
            ill_due.push_back(cycles + 2);
        end else if (dst != 5'd0) begin
            exp_due.push_back(cycles + 2);
            exp_addr.push_back(dst);
            exp_data.push_back(val);
            model_regs[dst] = val;
        end
    endtask

    task automatic idle();
        @(negedge clk);
        check_outputs();
        inst_valid = 1'b0;
        inst_data  = rand32();   // must be ignored
    endtask

    task automatic drain();
        repeat (DRAIN_LEN) idle();
    endtask

    task automatic immediate_ops();
        logic [31:0] r;
        logic [15:0] imm;
        for (int n = 1; n < 32; n++) begin
            r = rand32();
            issue(i_type(OP_LUI, 5'd0, 5'(n), r[31:16]));
            issue(i_type(OP_ORI, 5'(n), 5'(n), r[15:0]));
        end
        for (int n = 0; n < NR_ROUNDS; n++) begin
            for (int k = 0; k < 7; k++) begin
                r   = rand32();
                imm = r[15:0];
                if (IMM_OPS[k] == OP_ADDIU) begin
                    imm[15] = 1'b1;
                end
                issue(i_type(IMM_OPS[k], pick_reg(), pick_reg(), imm));
            end
        end
    endtask

    task automatic register_ops();
        for (int n = 0; n < NR_ROUNDS; n++) begin
            for (int k = 0; k < 8; k++) begin
                issue(r_type(REG_FNS[k], pick_reg(), pick_reg(), pick_reg(), 5'd0));
            end
        end
    endtask

    task automatic shift_ops();
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] r;
        for (int n = 0; n < NR_ROUNDS; n++) begin
            rt = pick_reg();
            if (rt == 5'd0) begin
                rt = 5'd1;
            end
            rd = pick_reg();
            if (rd == rt) begin
                rd = ~rt;
            end
            r = rand32();
            issue(i_type(OP_LUI, 5'd0, rt, r[15:0] | 16'h8000));   // negative source
            for (int k = 0; k < 3; k++) begin
                r = rand32();
                issue(r_type(SHIFT_FNS[k], 5'd0, rt, rd, r[10:6]));
            end
            for (int k = 3; k < 6; k++) begin
                issue(r_type(SHIFT_FNS[k], pick_reg(), rt, rd, 5'd0));
            end
        end
    endtask

    // gap 0 hits the result register, gap 1 the write-through, gap 2 a plain read
    task automatic forwarding_chains();
        logic [31:0] r;
        for (int gap = 0; gap < 3; gap++) begin
            for (int i = 0; i < CHAIN_LEN; i++) begin
                r = rand32();
                case (i % 3)
                    0: issue(i_type(OP_ADDIU, 5'd12, 5'd10, r[15:0]));
                    1: issue(r_type(FN_SUBU, 5'd12, 5'd10, 5'd11, 5'd0));
                    default: issue(r_type(FN_SLLV, 5'd10, 5'd11, 5'd12, 5'd0));
                endcase
                repeat (gap) idle();
            end
        end
    endtask

    task automatic zero_and_illegal();
        logic [31:0] w;
        logic        legal;
        logic [4:0]  dst;
        logic [31:0] val;
        issue(i_type(OP_ORI, 5'd1, 5'd0, 16'h5a5a));
        issue(r_type(FN_ADDU, 5'd0, 5'd0, 5'd5, 5'd0));   // no forward from r0
        issue(r_type(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(r_type(FN_OR, 5'd0, 5'd0, 5'd6, 5'd0));
        for (int n = 0; n < NR_ILLEGAL; n++) begin
            w = rand32();
            if (n % 2 == 0) begin
                w[31:26] = OP_SPECIAL;
            end
            predict(w, legal, dst, val);
            if (legal) begin
                if (w[31:26] == OP_SPECIAL) begin
                    w[5:0] = 6'h3f;
                end else begin
                    w[31:26] = 6'h3f;
                end
            end
            issue(w);
            issue(r_type(FN_XOR, w[20:16], 5'd0, 5'd29, 5'd0));
            issue(r_type(FN_XOR, w[15:11], 5'd0, 5'd28, 5'd0));
        end
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_data  = '0;
        for (int i = 0; i < `CORE_NR_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_LEN) @(negedge clk);
        rst = 1'b0;
        immediate_ops();
        drain();
        register_ops();
        drain();
        shift_ops();
        drain();
        forwarding_chains();
        drain();
        zero_and_illegal();
        drain();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== int_core.f ====
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/int_core.sv
testbench/tb_clock.sv
testbench/tb_int_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_int_core
FILELIST   := int_core.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
PASS_MSG   := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
